//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] xlen_t;	// Architectural word
	typedef logic [4:0]  reg_idx_t;
	typedef logic [2:0]  funct3_t;

	typedef enum logic [6:0] {
		OP_RTYPE  = 7'b0110011,
		OP_ITYPE  = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111
	} opcode_t;

	// Code is {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SUB    = 4'b1000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_SRA    = 4'b1101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_PASS_B = 4'b1111	// Spare code for LUI
	} alu_op_t;

	typedef enum logic [2:0] {
		IMM_I    = 3'd0,
		IMM_S    = 3'd1,
		IMM_B    = 3'd2,
		IMM_J    = 3'd3,
		IMM_U    = 3'd4,
		IMM_NONE = 3'd7
	} imm_sel_t;

	typedef enum logic [1:0] {
		WB_MEM = 2'd0,
		WB_ALU = 2'd1,
		WB_PC4 = 2'd2
	} wb_sel_t;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;
	localparam funct3_t F3_SRX  = 3'b101;	// SRLI and SRAI share funct3

endpackage

`default_nettype wire

//--- rtl/exec_map_pkg.sv
`default_nettype none

package exec_map_pkg;

	localparam int PADDR_W = 8;	// APB address width

	typedef logic [PADDR_W-1:0] paddr_t;

	localparam paddr_t ADDR_INST     = 8'h00;	// Instruction register
	localparam paddr_t ADDR_PC       = 8'h04;
	// x0..x31 at base + 4*n
	localparam paddr_t ADDR_REG_BASE = 8'h80;

endpackage

`default_nettype wire

//--- rtl/ctrl_unit.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_unit
	import rv_isa_pkg::*;
(
	input  xlen_t    inst_i,
	output logic     reg_wen_o,
	output alu_op_t  alu_sel_o,
	output logic     b_sel_o,
	output imm_sel_t imm_sel_o,
	output logic     mem_we_o,
	output wb_sel_t  wb_sel_o,
	output logic     br_un_o,
	output logic     a_sel_o,
	output logic     mem_valid_o
);

	opcode_t opcode;
	funct3_t funct3;
	logic    funct7_5;

	assign opcode   = opcode_t'(inst_i[6:0]);
	assign funct3   = inst_i[14:12];
	assign funct7_5 = inst_i[30];

	always_comb begin
		reg_wen_o   = 1'b0;
		alu_sel_o   = ALU_ADD;	// Address math by default
		b_sel_o     = 1'b1;
		a_sel_o     = 1'b0;
		imm_sel_o   = IMM_NONE;
		mem_we_o    = 1'b0;
		mem_valid_o = 1'b0;
		wb_sel_o    = WB_ALU;
		case (opcode)
			OP_RTYPE: begin
				reg_wen_o = 1'b1;
				alu_sel_o = alu_op_t'({funct7_5, funct3});
				b_sel_o   = 1'b0;	// rs2 operand
			end
			OP_ITYPE: begin
				reg_wen_o = 1'b1;
				// imm[10] only selects SRAI, else it is immediate data
				alu_sel_o = alu_op_t'({funct7_5 & (funct3 == F3_SRX), funct3});
				imm_sel_o = IMM_I;
			end
			OP_LOAD: begin
				reg_wen_o   = 1'b1;
				imm_sel_o   = IMM_I;
				mem_valid_o = 1'b1;
				wb_sel_o    = WB_MEM;
			end
			OP_STORE: begin
				imm_sel_o   = IMM_S;
				mem_we_o    = 1'b1;
				mem_valid_o = 1'b1;
			end
			OP_BRANCH: begin
				imm_sel_o = IMM_B;
				a_sel_o   = 1'b1;	// Target is PC relative
			end
			OP_JAL: begin
				reg_wen_o = 1'b1;
				imm_sel_o = IMM_J;
				a_sel_o   = 1'b1;
				wb_sel_o  = WB_PC4;
			end
			OP_JALR: begin
				reg_wen_o = 1'b1;
				imm_sel_o = IMM_I;
				wb_sel_o  = WB_PC4;
			end
			OP_LUI: begin
				reg_wen_o = 1'b1;
				imm_sel_o = IMM_U;
				alu_sel_o = ALU_PASS_B;
			end
			OP_AUIPC: begin
				reg_wen_o = 1'b1;
				imm_sel_o = IMM_U;
				a_sel_o   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign br_un_o = (funct3 == F3_BLTU) || (funct3 == F3_BGEU);

	always_comb begin
		assert (!mem_we_o || mem_valid_o)
			else $error("ctrl_unit: store without memory valid");
	end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen
	import rv_isa_pkg::*;
(
	input  xlen_t    inst_i,
	input  imm_sel_t imm_sel_i,
	output xlen_t    imm_o
);

	logic sign;

	assign sign = inst_i[31];	// Sign bit sits here in every format

	always_comb begin
		case (imm_sel_i)
			IMM_I: imm_o = {{20{sign}}, inst_i[31:20]};
			IMM_S: imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
			IMM_B: begin
				imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25],
					inst_i[11:8], 1'b0};
			end
			IMM_J: begin
				imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20],
					inst_i[30:21], 1'b0};
			end
			IMM_U: imm_o = {inst_i[31:12], 12'h000};
			default: imm_o = '0;	// IMM_NONE
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
	import rv_isa_pkg::*;
(
	input  xlen_t   a_i,
	input  xlen_t   b_i,
	input  alu_op_t alu_sel_i,
	output xlen_t   result_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (alu_sel_i)
			ALU_ADD:    result_o = a_i + b_i;
			ALU_SUB:    result_o = a_i - b_i;
			ALU_SLL:    result_o = a_i << shamt;
			ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
			ALU_SLTU:   result_o = {31'b0, a_i < b_i};
			ALU_XOR:    result_o = a_i ^ b_i;
			ALU_SRL:    result_o = a_i >> shamt;
			ALU_SRA:    result_o = xlen_t'($signed(a_i) >>> shamt);
			ALU_OR:     result_o = a_i | b_i;
			ALU_AND:    result_o = a_i & b_i;
			ALU_PASS_B: result_o = b_i;
			default:    result_o = '0;	// Unused codes
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
	import rv_isa_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     we_i,
	input  reg_idx_t rs1_i,
	input  reg_idx_t rs2_i,
	input  reg_idx_t rd_i,
	input  xlen_t    wdata_i,
	output xlen_t    rdata1_o,
	output xlen_t    rdata2_o
);

	xlen_t regs [32];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (rd_i != '0)) begin
			regs[rd_i] <= wdata_i;	// x0 writes dropped here
		end
	end

	assign rdata1_o = regs[rs1_i];
	assign rdata2_o = regs[rs2_i];

	assert property (@(posedge clk_i) disable iff (reset_i)
		(rs1_i == '0) |-> (rdata1_o == '0));

endmodule

`default_nettype wire

//--- rtl/rv_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top
	import rv_isa_pkg::*;
	import exec_map_pkg::*;
#(
	parameter int unsigned DMEM_WORDS = 16
) (
	input  logic   clk_i,
	input  logic   reset_i,
	input  logic   psel_i,
	input  logic   penable_i,
	input  logic   pwrite_i,
	input  paddr_t paddr_i,
	input  xlen_t  pwdata_i,
	output xlen_t  prdata_o,
	output logic   pready_o,
	output logic   pslverr_o
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	typedef enum logic {
		EXEC_IDLE,
		EXEC_RUN
	} exec_state_t;

	exec_state_t state_q;
	xlen_t       inst_q;
	xlen_t       pc_q;
	xlen_t       dmem [DMEM_WORDS];

	logic     access;
	logic     win_hit;
	logic     addr_hit;
	logic     inst_wr;
	logic     commit;
	paddr_t   win_off;
	reg_idx_t win_idx;

	logic     reg_wen;
	alu_op_t  alu_sel;
	logic     b_sel;
	logic     a_sel;
	imm_sel_t imm_sel;
	logic     mem_we;
	logic     mem_valid;
	wb_sel_t  wb_sel;
	logic     br_un;

	xlen_t    imm;
	reg_idx_t rf_rs1;
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	xlen_t    a_op;
	xlen_t    b_op;
	xlen_t    alu_res;
	xlen_t    pc_plus4;
	xlen_t    next_pc;
	xlen_t    mem_rdata;
	xlen_t    wb_data;
	funct3_t  funct3;
	logic     br_eq;
	logic     br_lt;
	logic     br_taken;
	logic [DMEM_AW-1:0] dmem_idx;

	// APB decode
	assign access   = psel_i && penable_i;
	assign win_off  = paddr_i - ADDR_REG_BASE;
	assign win_idx  = win_off[6:2];
	assign win_hit  = (paddr_i >= ADDR_REG_BASE) && (win_off[1:0] == 2'b00);
	assign addr_hit = (paddr_i == ADDR_INST) || (paddr_i == ADDR_PC) || win_hit;
	assign inst_wr  = access && pwrite_i && (paddr_i == ADDR_INST);
	assign commit   = (state_q == EXEC_RUN);

	// Wait state only for the first access cycle of an instruction write
	assign pready_o  = access && !(inst_wr && (state_q == EXEC_IDLE));
	assign pslverr_o = access && !addr_hit;

	always_comb begin
		prdata_o = '0;
		if (paddr_i == ADDR_INST) begin
			prdata_o = inst_q;
		end else if (paddr_i == ADDR_PC) begin
			prdata_o = pc_q;
		end else if (win_hit) begin
			prdata_o = rs1_data;	// Host borrows read port 1
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= EXEC_IDLE;
			inst_q  <= '0;
		end else begin
			case (state_q)
				EXEC_IDLE: begin
					if (inst_wr) begin
						state_q <= EXEC_RUN;
						inst_q  <= pwdata_i;
					end
				end
				default: state_q <= EXEC_IDLE;	// Retires on this edge
			endcase
		end
	end

	ctrl_unit u_ctrl (
		.inst_i      (inst_q),
		.reg_wen_o   (reg_wen),
		.alu_sel_o   (alu_sel),
		.b_sel_o     (b_sel),
		.imm_sel_o   (imm_sel),
		.mem_we_o    (mem_we),
		.wb_sel_o    (wb_sel),
		.br_un_o     (br_un),
		.a_sel_o     (a_sel),
		.mem_valid_o (mem_valid)
	);

	imm_gen u_imm (
		.inst_i    (inst_q),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	assign rf_rs1 = commit ? inst_q[19:15] : win_idx;

	reg_file u_rf (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.we_i     (commit && reg_wen),
		.rs1_i    (rf_rs1),
		.rs2_i    (inst_q[24:20]),
		.rd_i     (inst_q[11:7]),
		.wdata_i  (wb_data),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	assign a_op = a_sel ? pc_q : rs1_data;
	assign b_op = b_sel ? imm : rs2_data;

	alu u_alu (
		.a_i       (a_op),
		.b_i       (b_op),
		.alu_sel_i (alu_sel),
		.result_o  (alu_res)
	);

	// Branch compare
	assign funct3 = inst_q[14:12];
	assign br_eq  = (rs1_data == rs2_data);
	assign br_lt  = br_un ? (rs1_data < rs2_data) : ($signed(rs1_data) < $signed(rs2_data));

	always_comb begin
		case (funct3)
			F3_BEQ:  br_taken = br_eq;
			F3_BNE:  br_taken = !br_eq;
			F3_BLT:  br_taken = br_lt;
			F3_BGE:  br_taken = !br_lt;
			F3_BLTU: br_taken = br_lt;
			F3_BGEU: br_taken = !br_lt;
			default: br_taken = 1'b0;
		endcase
		if (opcode_t'(inst_q[6:0]) != OP_BRANCH) begin
			br_taken = 1'b0;
		end
	end

	assign pc_plus4 = pc_q + 32'd4;
	assign next_pc  = (br_taken || (wb_sel == WB_PC4)) ? {alu_res[31:1], 1'b0} : pc_plus4;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_q <= '0;
		end else if (commit) begin
			pc_q <= next_pc;
		end else if (access && pwrite_i && (paddr_i == ADDR_PC)) begin
			pc_q <= pwdata_i;
		end
	end

	// Word memory with wrapping address
	assign dmem_idx  = alu_res[DMEM_AW+1:2];
	assign mem_rdata = mem_valid ? dmem[dmem_idx] : '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (commit && mem_we) begin
			dmem[dmem_idx] <= rs2_data;
		end
	end

	always_comb begin
		case (wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			WB_PC4:  wb_data = pc_plus4;
			default: wb_data = alu_res;
		endcase
	end

	assert property (@(posedge clk_i) disable iff (reset_i)
		pready_o |-> (psel_i && penable_i));

	assert property (@(posedge clk_i) disable iff (reset_i)
		(state_q == EXEC_RUN) |=> (state_q == EXEC_IDLE));

endmodule

`default_nettype wire

//--- verification/exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exec_checker
	import rv_isa_pkg::*;
	import exec_map_pkg::*;
#(
	parameter int unsigned DMEM_WORDS = 16
) (
	input  logic   clk_i,
	input  logic   reset_i,
	input  logic   psel_i,
	input  logic   penable_i,
	input  logic   pwrite_i,
	input  paddr_t paddr_i,
	input  xlen_t  pwdata_i,
	input  xlen_t  prdata_i,
	input  logic   pready_i,
	input  logic   pslverr_i,
	output int     checks_o,
	output int     errors_o
);

	xlen_t xr [32];
	xlen_t mem [DMEM_WORDS];
	xlen_t pc;
	int    waits;
	string group;	// Last instruction class for check names

	function automatic xlen_t arith(input logic [2:0] f3, input logic alt,
		input xlen_t a, input xlen_t b);
		xlen_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) begin
					r = $signed(a) >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic execute(input xlen_t inst);
		logic [2:0] f3;
		xlen_t      a;
		xlen_t      b;
		xlen_t      imm_i;
		xlen_t      res;
		xlen_t      npc;
		logic       wr;
		logic       taken;
		int         idx;
		f3    = inst[14:12];
		a     = xr[inst[19:15]];
		b     = xr[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		npc   = pc + 32'd4;
		res   = '0;
		wr    = 1'b1;
		case (inst[6:0])
			OP_RTYPE: begin
				group = "R-type";
				res   = arith(f3, inst[30], a, b);
			end
			OP_ITYPE: begin
				group = "I-type";
				res   = arith(f3, inst[30] && (f3 == 3'd5), a, imm_i);	// Only SRAI uses bit 30
			end
			OP_LOAD: begin
				group = "LW";
				idx   = int'(((a + imm_i) >> 2) % DMEM_WORDS);
				res   = mem[idx];
			end
			OP_STORE: begin
				group    = "SW";
				wr       = 1'b0;
				idx      = int'(((a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2) % DMEM_WORDS);
				mem[idx] = b;
			end
			OP_BRANCH: begin
				group = "branch";
				wr    = 1'b0;
				case (f3)
					F3_BEQ:  taken = (a == b);
					F3_BNE:  taken = (a != b);
					F3_BLT:  taken = ($signed(a) < $signed(b));
					F3_BGE:  taken = ($signed(a) >= $signed(b));
					F3_BLTU: taken = (a < b);
					default: taken = (a >= b);
				endcase
				if (taken) begin
					npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				end
			end
			OP_JAL: begin
				group = "JAL";
				res   = npc;
				npc   = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			OP_JALR: begin
				group = "JALR";
				res   = npc;
				npc   = (a + imm_i) & ~32'd1;
			end
			OP_LUI: begin
				group = "LUI";
				res   = {inst[31:12], 12'h000};
			end
			OP_AUIPC: begin
				group = "AUIPC";
				res   = pc + {inst[31:12], 12'h000};
			end
			default: begin
				group = "unknown opcode";
				wr    = 1'b0;
			end
		endcase
		if (wr && inst[11:7] != 5'd0) begin
			xr[inst[11:7]] = res;
		end
		pc = npc;
	endtask

	task automatic compare(input string name, input xlen_t exp, input xlen_t act);
		checks_o++;
		if (exp !== act) begin
			errors_o++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic close_transfer();
		paddr_t off;
		logic   mapped;
		int     exp_waits;
		off       = paddr_i - ADDR_REG_BASE;
		mapped    = (paddr_i == ADDR_INST) || (paddr_i == ADDR_PC) ||
			((paddr_i >= ADDR_REG_BASE) && (paddr_i[1:0] == 2'b00));
		exp_waits = (pwrite_i && paddr_i == ADDR_INST) ? 1 : 0;	// One cycle to execute
		compare($sformatf("wait states at %h", paddr_i), xlen_t'(exp_waits), xlen_t'(waits));
		compare($sformatf("pslverr at %h", paddr_i), {31'b0, !mapped}, {31'b0, pslverr_i});
		if (mapped && pwrite_i) begin
			if (paddr_i == ADDR_INST) begin
				execute(pwdata_i);
			end else if (paddr_i == ADDR_PC) begin
				pc = pwdata_i;
			end
		end else if (mapped && paddr_i == ADDR_PC) begin
			compare({"after ", group, " read pc"}, pc, prdata_i);
		end else if (mapped && paddr_i != ADDR_INST) begin
			compare($sformatf("after %s read x%0d", group, off[6:2]), xr[off[6:2]], prdata_i);
		end
	endtask

	// Bus is stable at the falling edge
	always @(negedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				xr[i] = '0;
			end
			for (int i = 0; i < int'(DMEM_WORDS); i++) begin
				mem[i] = '0;
			end
			pc    = '0;
			waits = 0;
			group = "reset";
		end else if (psel_i && penable_i) begin
			if (!pready_i) begin
				waits++;
			end else begin
				close_transfer();
				waits = 0;
			end
		end else if (pready_i || pslverr_i) begin
			errors_o++;
			$display("pready or pslverr went high outside an access cycle");
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_rv_exec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_exec
	import rv_isa_pkg::*;
	import exec_map_pkg::*;
();

	localparam int unsigned DMEM_WORDS = 16;
	localparam int  N_INST       = 400;
	localparam int  RESET_CYCLES = 10;
	localparam time CLK_PERIOD   = 100;
	// 12 cycles per instruction, two register scans, reset
	localparam int  LIMIT_CYCLES = N_INST * 12 + 2 * 33 * 3 + RESET_CYCLES;

	logic   clk_i = 1'b0;
	logic   reset_i;
	logic   psel_i;
	logic   penable_i;
	logic   pwrite_i;
	paddr_t paddr_i;
	xlen_t  pwdata_i;
	xlen_t  prdata_o;
	logic   pready_o;
	logic   pslverr_o;
	int     checks;
	int     errors;
	integer seed;

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	rv_exec_top #(
		.DMEM_WORDS (DMEM_WORDS)
	) DUT (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o)
	);

	exec_checker #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_checker (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_i  (prdata_o),
		.pready_i  (pready_o),
		.pslverr_i (pslverr_o),
		.checks_o  (checks),
		.errors_o  (errors)
	);

	task automatic transfer(input logic wr, input paddr_t addr, input xlen_t data);
		@(posedge clk_i);
		psel_i    <= 1'b1;	// Setup cycle
		penable_i <= 1'b0;
		pwrite_i  <= wr;
		paddr_i   <= addr;
		pwdata_i  <= data;
		@(posedge clk_i);
		penable_i <= 1'b1;
		@(negedge clk_i);
		while (!pready_o) begin
			@(negedge clk_i);
		end
		@(posedge clk_i);	// Transfer completes here
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic issue(input xlen_t inst);
		transfer(1'b1, ADDR_INST, inst);
	endtask

	task automatic read_reg(input reg_idx_t idx);
		transfer(1'b0, ADDR_REG_BASE + {1'b0, idx, 2'b00}, '0);
	endtask

	task automatic scan_registers();
		for (int i = 0; i < 32; i++) begin
			read_reg(i[4:0]);
		end
	endtask

	initial begin
		xlen_t      inst;
		xlen_t      rnd;
		xlen_t      imm;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		int         kind;
		int         issued;
		seed      = 32'hc91b_df4e;
		reset_i   = 1'b1;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = '0;
		pwdata_i  = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		reset_i <= 1'b0;
		transfer(1'b0, ADDR_PC, '0);
		scan_registers();
		transfer(1'b1, 8'h08, 32'h1234_5678);	// Outside the map
		transfer(1'b0, 8'h7c, '0);
		transfer(1'b0, 8'h82, '0);	// Misaligned window address
		issued = 0;
		while (issued < N_INST) begin
			rnd  = $random(seed);
			imm  = $random(seed);
			kind = int'(rnd[7:0]) % 9;
			rd   = rnd[12:8];
			rs1  = rnd[17:13];
			rs2  = rnd[22:18];
			f3   = rnd[25:23];
			case (kind)
				0: begin
					f7   = (rnd[26] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
					inst = {f7, rs2, rs1, f3, rd, OP_RTYPE};
				end
				1, 2: begin
					f7 = (rnd[26] && f3 == 3'd5) ? 7'h20 : 7'h00;
					if (f3 == 3'd1 || f3 == 3'd5) begin
						inst = {f7, imm[4:0], rs1, f3, rd, OP_ITYPE};	// Shift amount
					end else begin
						inst = {imm[11:0], rs1, f3, rd, OP_ITYPE};
					end
				end
				3: inst = {imm[31:12], rd, rnd[26] ? OP_LUI : OP_AUIPC};
				4: inst = {imm[31:12], rd, OP_JAL};
				5: inst = {imm[11:0], rs1, 3'b000, rd, OP_JALR};
				6: begin
					if (f3[2:1] == 2'b01) begin
						f3 = {1'b1, f3[0], 1'b0};	// No branch on 010 or 011
					end
					inst = {imm[31:25], rs2, rs1, f3, imm[11:7], OP_BRANCH};
				end
				7: begin
					issue({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE});
					issued++;
					transfer(1'b0, ADDR_PC, '0);
					inst = {imm[11:0], rs1, 3'b010, rd, OP_LOAD};	// Same word back
				end
				default: inst = {imm[11:0], rs1, 3'b010, rd, OP_LOAD};
			endcase
			issue(inst);
			issued++;
			read_reg(rd);
			transfer(1'b0, ADDR_PC, '0);
		end
		scan_registers();
		repeat (2) @(posedge clk_i);
		$display("Closing: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d clock cycles", LIMIT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
rtl/rv_isa_pkg.sv
rtl/exec_map_pkg.sv
rtl/ctrl_unit.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/rv_exec_top.sv
verification/exec_checker.sv
verification/tb_rv_exec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_rv_exec \
	-f src.f -o sim_exec > build.log 2>&1 \
	&& ./obj_dir/sim_exec > sim.log 2>&1 \
	&& grep -q "^Simulation finished: PASS$" sim.log \
	&& echo "Run passed, see sim.log" \
	|| { echo "Run failed, see build.log and sim.log"; exit 1; }
